/* include/ps2_config.svh */
`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// equal samples a pin needs before its filtered level follows
`define PS2_FILTER_LEN 4

// system cycles without a keyboard clock fall before a partial frame is dropped
// has to exceed one keyboard clock period counted in system cycles
`define PS2_TIMEOUT_CYCLES 400

// set 2 make codes of the shift keys
`define PS2_SHIFT_L 8'h12
`define PS2_SHIFT_R 8'h59

`endif

/* list.f */
+incdir+include
src/ps2_pkg.sv
src/ps2_line_sync.sv
src/ps2_frame_rx.sv
src/ps2_scan_decode.sv
src/ps2_char_map.sv
src/ps2_kb.sv
tests/ps2_clk_gen.sv
tests/ps2_kb_assert.sv
tests/ps2_kb_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the PS/2 keyboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ps2_kb_tb -f list.f -Mdir obj_dir

out=$(./obj_dir/Vps2_kb_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TEST PASS"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* src/ps2_char_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ps2_config.svh"

module ps2_char_map (
  input  wire               clk,
  input  wire               rst_n,
  input  ps2_pkg::ps2_key_t key_i,
  input  wire               key_valid_i,
  output logic [7:0]        char_o,
  output logic              char_valid_o  // one cycle after key_valid_i
);

  import ps2_pkg::*;

  logic       shift_q;  // either shift held
  logic       is_shift;
  logic       hit;      // code is in the table
  logic       letter;   // a..z, affected by shift
  logic [7:0] ascii;    // lower case / digit value

  // shift keys only count without E0
  assign is_shift = !key_i.extended &&
                    (key_i.code == `PS2_SHIFT_L || key_i.code == `PS2_SHIFT_R);

  // set 2 table
  always_comb begin
    hit    = 1'b1;
    letter = 1'b1;
    unique case (key_i.code)
      8'h1C: ascii = "a";
      8'h32: ascii = "b";
      8'h21: ascii = "c";
      8'h23: ascii = "d";
      8'h24: ascii = "e";
      8'h2B: ascii = "f";
      8'h34: ascii = "g";
      8'h33: ascii = "h";
      8'h43: ascii = "i";
      8'h3B: ascii = "j";
      8'h42: ascii = "k";
      8'h4B: ascii = "l";
      8'h3A: ascii = "m";
      8'h31: ascii = "n";
      8'h44: ascii = "o";
      8'h4D: ascii = "p";
      8'h15: ascii = "q";
      8'h2D: ascii = "r";
      8'h1B: ascii = "s";
      8'h2C: ascii = "t";
      8'h3C: ascii = "u";
      8'h2A: ascii = "v";
      8'h1D: ascii = "w";
      8'h22: ascii = "x";
      8'h35: ascii = "y";
      8'h1A: ascii = "z";
      default: begin
        letter = 1'b0;
        unique case (key_i.code)
          8'h45: ascii = "0";
          8'h16: ascii = "1";
          8'h1E: ascii = "2";
          8'h26: ascii = "3";
          8'h25: ascii = "4";
          8'h2E: ascii = "5";
          8'h36: ascii = "6";
          8'h3D: ascii = "7";
          8'h3E: ascii = "8";
          8'h46: ascii = "9";
          8'h29: ascii = " ";
          8'h5A: ascii = 8'h0D; // enter gives carriage return
          default: begin
            ascii = 8'h00;
            hit   = 1'b0;
          end
        endcase
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q      <= 1'b0;
      char_valid_o <= 1'b0;
    end else begin
      char_valid_o <= 1'b0;
      if (key_valid_i && is_shift) shift_q <= !key_i.released; // make sets, break clears
      else if (key_valid_i && !key_i.extended && !key_i.released && hit)
        char_valid_o <= 1'b1;
    end
  end

  // character payload, upper case is 20h below lower case
  always_ff @(posedge clk) begin
    if (key_valid_i) char_o <= (letter && shift_q) ? ascii - 8'h20 : ascii;
  end

endmodule

`default_nettype wire

/* src/ps2_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ps2_config.svh"

module ps2_frame_rx (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 fall_i,        // keyboard clock fell, sample now
  input  wire                 dat_i,
  output ps2_pkg::ps2_frame_t frame_o,
  output logic                frame_valid_o, // good frame, one cycle
  output logic                err_o          // bad parity/stop or timeout, one cycle
);

  import ps2_pkg::*;

  localparam int TIMEOUT = `PS2_TIMEOUT_CYCLES;
  localparam int TW      = $clog2(TIMEOUT + 1);

  ps2_rx_state_e state_q;
  logic [2:0]    bit_cnt_q;  // data bit index
  logic          par_q;      // xor of data and parity bits so far
  logic [7:0]    shift_q;    // data bits, lsb arrives first
  logic [TW-1:0] idle_cnt_q; // cycles since the last fall
  logic          timeout_hit;

  // a partial frame stalled too long, only when no edge is arriving
  assign timeout_hit = (state_q != IDLE) && !fall_i && (idle_cnt_q == TW'(TIMEOUT - 1));

  assign frame_o = '{data: shift_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      bit_cnt_q     <= 3'd0;
      par_q         <= 1'b0;
      idle_cnt_q    <= '0;
      frame_valid_o <= 1'b0;
      err_o         <= 1'b0;
    end else begin
      frame_valid_o <= 1'b0; // strobes by default
      err_o         <= 1'b0;

      if (fall_i || state_q == IDLE) idle_cnt_q <= '0;
      else                           idle_cnt_q <= idle_cnt_q + 1'b1;

      if (timeout_hit) begin
        state_q <= IDLE; // drop the partial frame
        err_o   <= 1'b1;
      end else if (fall_i) begin
        unique case (state_q)
          IDLE: begin
            if (!dat_i) begin // start bit must be 0, a 1 is ignored
              state_q   <= DATA;
              bit_cnt_q <= 3'd0;
              par_q     <= 1'b0;
            end
          end
          DATA: begin
            par_q     <= par_q ^ dat_i;
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) state_q <= PARITY;
          end
          PARITY: begin
            par_q   <= par_q ^ dat_i; // must end up 1 for odd parity
            state_q <= STOP;
          end
          STOP: begin
            state_q <= IDLE;
            if (par_q && dat_i) frame_valid_o <= 1'b1;
            else                err_o         <= 1'b1;
          end
        endcase
      end
    end
  end

  // payload, stable from the last data bit until the next frame's data
  always_ff @(posedge clk) begin
    if (fall_i && state_q == DATA) shift_q <= {dat_i, shift_q[7:1]};
  end

endmodule

`default_nettype wire

/* src/ps2_kb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_kb (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               ps2_clk_i,    // keyboard clock pin
  input  wire               ps2_dat_i,    // keyboard data pin
  output ps2_pkg::ps2_key_t key_o,
  output logic              key_valid_o,
  output logic [7:0]        char_o,
  output logic              char_valid_o,
  output logic              frame_err_o   // parity, stop or timeout error
);

  import ps2_pkg::*;

  logic       fall;        // filtered keyboard clock fall
  logic       dat;         // filtered data level
  ps2_frame_t frame;
  logic       frame_valid;

  ps2_line_sync u_sync (
    .clk       (clk),
    .rst_n     (rst_n),
    .ps2_clk_i (ps2_clk_i),
    .ps2_dat_i (ps2_dat_i),
    .fall_o    (fall),
    .dat_o     (dat)
  );

  ps2_frame_rx u_frame (
    .clk           (clk),
    .rst_n         (rst_n),
    .fall_i        (fall),
    .dat_i         (dat),
    .frame_o       (frame),
    .frame_valid_o (frame_valid),
    .err_o         (frame_err_o)
  );

  ps2_scan_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_i       (frame),
    .frame_valid_i (frame_valid),
    .key_o         (key_o),
    .key_valid_o   (key_valid_o)
  );

  ps2_char_map u_char (
    .clk          (clk),
    .rst_n        (rst_n),
    .key_i        (key_o),
    .key_valid_i  (key_valid_o),
    .char_o       (char_o),
    .char_valid_o (char_valid_o)
  );

endmodule

`default_nettype wire

/* src/ps2_line_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ps2_config.svh"

module ps2_line_sync (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  ps2_clk_i, // async keyboard clock
  input  wire  ps2_dat_i, // async keyboard data
  output logic fall_o,    // one cycle per filtered clock fall
  output logic dat_o      // filtered data level
);

  localparam int FLT = `PS2_FILTER_LEN;
  localparam int CW  = $clog2(FLT + 1);

  logic [1:0]    pin_raw;  // bit 1 clock, bit 0 data
  logic [1:0]    sync_q1;
  logic [1:0]    sync_q2;
  logic [1:0]    filt_q;   // deglitched levels
  logic [CW-1:0] agree_cnt_q [2];
  logic          clk_d_q;  // filtered clock one cycle late

  assign pin_raw = {ps2_clk_i, ps2_dat_i};

  // two-flop synchronizer, lines idle high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= 2'b11;
      sync_q2 <= 2'b11;
    end else begin
      sync_q1 <= pin_raw;
      sync_q2 <= sync_q1;
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_filt
    // count samples that disagree with the filtered level, flip after FLT in a row
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        agree_cnt_q[i] <= '0;
        filt_q[i]      <= 1'b1;
      end else if (sync_q2[i] == filt_q[i]) begin
        agree_cnt_q[i] <= '0; // glitch ended, start over
      end else if (agree_cnt_q[i] == CW'(FLT - 1)) begin
        agree_cnt_q[i] <= '0;
        filt_q[i]      <= sync_q2[i];
      end else begin
        agree_cnt_q[i] <= agree_cnt_q[i] + 1'b1;
      end
    end
  end

  // registered outputs, data and edge line up in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_d_q <= 1'b1;
      fall_o  <= 1'b0;
      dat_o   <= 1'b1;
    end else begin
      clk_d_q <= filt_q[1];
      fall_o  <= clk_d_q & ~filt_q[1]; // high to low on the filtered clock
      dat_o   <= filt_q[0];
    end
  end

endmodule

`default_nettype wire

/* src/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

  // frame receiver FSM
  typedef enum logic [1:0] {
    IDLE   = 2'd0, // waiting for a start bit
    DATA   = 2'd1, // eight data bits, lsb first
    PARITY = 2'd2, // odd parity bit
    STOP   = 2'd3  // stop bit, must be 1
  } ps2_rx_state_e;

  // scan code decoder FSM, remembers E0/F0 prefixes
  typedef enum logic [1:0] {
    BASE    = 2'd0,
    EXT     = 2'd1, // E0 seen
    BRK     = 2'd2, // F0 seen
    EXT_BRK = 2'd3  // E0 then F0
  } ps2_dec_state_e;

  // one received byte
  typedef struct packed {
    logic [7:0] data;
  } ps2_frame_t;

  // key event, 10 bits
  typedef struct packed {
    logic [7:0] code;     // set 2 scan code without prefixes
    logic       extended; // E0 came first
    logic       released; // F0 came first, break event
  } ps2_key_t;

endpackage

`default_nettype wire

/* src/ps2_scan_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_scan_decode (
  input  wire                 clk,
  input  wire                 rst_n,
  input  ps2_pkg::ps2_frame_t frame_i,
  input  wire                 frame_valid_i,
  output ps2_pkg::ps2_key_t   key_o,
  output logic                key_valid_o    // one cycle after frame_valid_i
);

  import ps2_pkg::*;

  localparam logic [7:0] CODE_EXT = 8'hE0; // extended prefix
  localparam logic [7:0] CODE_BRK = 8'hF0; // break prefix

  ps2_dec_state_e state_q;
  logic           is_ext;
  logic           is_brk;

  assign is_ext = (state_q == EXT) || (state_q == EXT_BRK);
  assign is_brk = (state_q == BRK) || (state_q == EXT_BRK);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= BASE;
      key_valid_o <= 1'b0;
    end else begin
      key_valid_o <= 1'b0;
      if (frame_valid_i) begin
        if (frame_i.data == CODE_EXT) begin
          state_q <= is_brk ? EXT_BRK : EXT; // keep a pending break
        end else if (frame_i.data == CODE_BRK) begin
          state_q <= is_ext ? EXT_BRK : BRK;
        end else begin
          key_valid_o <= 1'b1; // real code, emit and forget prefixes
          state_q     <= BASE;
        end
      end
    end
  end

  // event payload, no reset
  always_ff @(posedge clk) begin
    if (frame_valid_i && frame_i.data != CODE_EXT && frame_i.data != CODE_BRK) begin
      key_o.code     <= frame_i.data;
      key_o.extended <= is_ext;
      key_o.released <= is_brk;
    end
  end

endmodule

`default_nettype wire

/* tests/ps2_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns system clock
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1; // released just after the 5th edge
  end

endmodule

`default_nettype wire

/* tests/ps2_kb_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_kb_assert (
  input wire clk,
  input wire rst_n,
  input wire key_valid_i,
  input wire char_valid_i,
  input wire frame_err_i
);

  // nothing can be decoded yet in the first cycle out of reset
  a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !key_valid_i)
    else $error("key event in the first cycle after reset");

  // a character always follows its key event by one cycle
  a_char_after_key: assert property (@(posedge clk) disable iff (!rst_n)
    char_valid_i |-> $past(key_valid_i))
    else $error("character strobe without a key event one cycle earlier");

  // frames are hundreds of cycles apart
  a_key_not_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
    key_valid_i |=> !key_valid_i)
    else $error("key events in two consecutive cycles");

  a_err_key_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(frame_err_i && key_valid_i))
    else $error("frame error and key event in the same cycle");

endmodule

bind ps2_kb ps2_kb_assert u_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .key_valid_i  (key_valid_o),
  .char_valid_i (char_valid_o),
  .frame_err_i  (frame_err_o)
);

`default_nettype wire

/* tests/ps2_kb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ps2_config.svh"

module ps2_kb_tb;

  import ps2_pkg::*;

  localparam int KB_HALF    = 30; // keyboard clock half period in system cycles
  localparam int WAIT_LIMIT = `PS2_TIMEOUT_CYCLES + 200;

  // set 2 codes of a..z and 0..9, in alphabet / digit order
  localparam logic [7:0] LETTER_CODES [26] = '{
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A,
    8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
  localparam logic [7:0] DIGIT_CODES [10] = '{
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};

  logic       clk;
  logic       rst_n;
  logic       ps2_clk;
  logic       ps2_dat;
  ps2_key_t   key;
  logic       key_valid;
  logic [7:0] ch;
  logic       char_valid;
  logic       frame_err;

  ps2_key_t   exp_keys [$];
  ps2_key_t   got_keys [$];
  logic [7:0] exp_chars [$];
  logic [7:0] got_chars [$];
  int         err_exp;     // frame errors the model expects
  int         err_seen;    // frame_err_o pulses seen
  int         key_errs;
  int         char_errs;
  int         other_errs;
  logic       ref_ext;     // model prefix and shift state
  logic       ref_brk;
  logic       ref_shift;
  logic [15:0] lfsr;

  ps2_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  ps2_kb u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ps2_clk_i    (ps2_clk),
    .ps2_dat_i    (ps2_dat),
    .key_o        (key),
    .key_valid_o  (key_valid),
    .char_o       (ch),
    .char_valid_o (char_valid),
    .frame_err_o  (frame_err)
  );

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr); // one step per bit
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  function automatic ps2_key_t ref_key(input logic [7:0] code, input logic ext, input logic brk);
    ps2_key_t k;
    k.code     = code;
    k.extended = ext;
    k.released = brk;
    return k;
  endfunction

  // bit 8 says the code is mapped
  function automatic logic [8:0] ref_char(input logic [7:0] code, input logic shift);
    logic [8:0] res;
    res = 9'h000;
    for (int i = 0; i < 26; i++)
      if (LETTER_CODES[i] == code) res = {1'b1, (shift ? 8'h41 : 8'h61) + 8'(i)};
    for (int i = 0; i < 10; i++)
      if (DIGIT_CODES[i] == code) res = {1'b1, 8'h30 + 8'(i)}; // shift ignored
    if (code == 8'h29) res = {1'b1, 8'h20};
    if (code == 8'h5A) res = {1'b1, 8'h0D};                     // enter is CR
    return res;
  endfunction

  // feed one good byte to the model
  task automatic model_byte(input logic [7:0] b);
    ps2_key_t   k;
    logic [8:0] c;
    if (b == 8'hE0) ref_ext = 1'b1;
    else if (b == 8'hF0) ref_brk = 1'b1;
    else begin
      k = ref_key(b, ref_ext, ref_brk);
      c = ref_char(b, ref_shift);
      exp_keys.push_back(k);
      if (!k.extended && (b == 8'h12 || b == 8'h59)) ref_shift = !k.released;
      else if (!k.extended && !k.released && c[8]) exp_chars.push_back(c[7:0]);
      ref_ext = 1'b0;
      ref_brk = 1'b0;
    end
  endtask

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1; // inputs move just after the edge
  endtask

  // nbits below 11 cuts the frame short
  task automatic send_frame(input logic [7:0] data, input logic bad_par, input logic bad_stop,
                            input int nbits);
    logic [10:0] bits;
    bits = {~bad_stop, ~(^data) ^ bad_par, data, 1'b0}; // stop, odd parity, data, start
    for (int i = 0; i < nbits; i++) begin
      step(KB_HALF / 2);
      ps2_dat = bits[i]; // data changes mid clock-high
      step(KB_HALF / 2);
      ps2_clk = 1'b0;    // host samples on this fall
      step(KB_HALF);
      ps2_clk = 1'b1;
    end
    step(KB_HALF / 2);
    ps2_dat = 1'b1;
    step(2 * KB_HALF);   // idle gap
  endtask

  task automatic send_byte(input logic [7:0] b);
    model_byte(b);
    send_frame(b, 1'b0, 1'b0, 11);
  endtask

  task automatic check_key(input string name, input ps2_key_t exp, input ps2_key_t act);
    if (exp !== act) begin
      key_errs++;
      $display("error %s: key expected code %h ext %b rel %b, actual code %h ext %b rel %b",
               name, exp.code, exp.extended, exp.released, act.code, act.extended,
               act.released);
    end
  endtask

  task automatic check_char(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      char_errs++;
      $display("error %s: char expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input int exp, input int act);
    if (exp != act) begin
      other_errs++;
      $display("error %s: frame errors expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // wait for all expected events, then match them in order
  task automatic expect_results(input string name);
    int waited;
    waited = 0;
    while ((got_keys.size() < exp_keys.size() || got_chars.size() < exp_chars.size() ||
            err_seen < err_exp) && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) begin
      other_errs++;
      $display("%s: timed out waiting for events from the DUT", name);
    end
    step(4); // let stray events show up
    while (exp_keys.size() > 0 && got_keys.size() > 0)
      check_key(name, exp_keys.pop_front(), got_keys.pop_front());
    while (exp_chars.size() > 0 && got_chars.size() > 0)
      check_char(name, exp_chars.pop_front(), got_chars.pop_front());
    if (exp_keys.size() + exp_chars.size() + got_keys.size() + got_chars.size() != 0) begin
      other_errs++;
      $display("%s: %0d key and %0d char events missing, %0d key and %0d char events extra",
               name, exp_keys.size(), exp_chars.size(), got_keys.size(), got_chars.size());
      exp_keys.delete();
      exp_chars.delete();
      got_keys.delete();
      got_chars.delete();
    end
    check_err(name, err_exp, err_seen);
    err_seen = err_exp; // resync after a mismatch
  endtask

  // monitor, sampled mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (key_valid)  got_keys.push_back(key);
      if (char_valid) got_chars.push_back(ch);
      if (frame_err)  err_seen++;
    end
  end

  initial begin
    logic [15:0] r;
    int          idx;
    int          waited;
    ps2_clk    = 1'b1; // lines idle high
    ps2_dat    = 1'b1;
    lfsr       = 16'd26871;
    ref_ext    = 1'b0;
    ref_brk    = 1'b0;
    ref_shift  = 1'b0;
    err_exp    = 0;
    err_seen   = 0;
    key_errs   = 0;
    char_errs  = 0;
    other_errs = 0;

    waited = 0;
    while (!rst_n && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      other_errs++;
      $display("reset was never released");
    end
    step(20);

    for (int n = 0; n < 12; n++) begin // random letters and digits
      take_bits(6, r);
      idx = int'(r) % 36;
      send_byte(idx < 26 ? LETTER_CODES[idx] : DIGIT_CODES[idx - 26]);
    end
    send_byte(8'h29);
    send_byte(8'h5A);
    expect_results("random_make");

    send_byte(8'hF0);
    send_byte(8'h1C);
    expect_results("break");
    send_byte(8'hF0);
    expect_results("break_prefix_alone"); // no event yet
    send_byte(8'h45);
    expect_results("break_after_prefix");

    send_byte(8'h12); // left shift held
    send_byte(8'h1C);
    send_byte(8'h16); // digit ignores shift
    send_byte(8'hF0);
    send_byte(8'h12);
    send_byte(8'h32);
    send_byte(8'h59); // right shift
    send_byte(8'h1A);
    send_byte(8'hF0);
    send_byte(8'h59);
    send_byte(8'h1A);
    expect_results("shift");

    send_byte(8'hE0);
    send_byte(8'h75);
    send_byte(8'hE0);
    send_byte(8'h1C); // mapped but extended, no char
    send_byte(8'hE0);
    send_byte(8'hF0);
    send_byte(8'h75);
    expect_results("extended");

    send_frame(8'h1C, 1'b1, 1'b0, 11); // even parity
    err_exp++;
    expect_results("parity_error");
    send_byte(8'h24);
    send_frame(8'h2B, 1'b0, 1'b1, 11); // stop bit 0
    err_exp++;
    expect_results("stop_error");
    send_byte(8'h1C);
    expect_results("after_frame_error");

    send_frame(8'h4D, 1'b0, 1'b0, 6);  // start and five data bits only
    err_exp++;
    expect_results("timeout");
    send_byte(8'h44);
    expect_results("after_timeout");

    $display("errors: key %0d, char %0d, other %0d", key_errs, char_errs, other_errs);
    if (key_errs + char_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
